// ==== Makefile ====
TOP = map_090_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)
	obj_dir/$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== include/map_defs.svh ====
`ifndef MAP_DEFS_SVH
`define MAP_DEFS_SVH

// PRG ROM address: outer bits, 6-bit 8K bank, 13-bit offset
`define MAP_PRG_AW 21

// CHR address: outer bits, A18, 8-bit 1K bank, 10-bit offset
`define MAP_CHR_AW 21

// multiplier and accumulator, $5800-$5803
`define MAP_MUL_BASE 16'h5800

// IRQ control, $C000-$C006
`define MAP_IRQ_BASE 16'hC000

// mode registers, $D000-$D003
`define MAP_MODE_BASE 16'hD000

`endif

// ==== src.f ====
+incdir+include
verilog/map_pkg.sv
verilog/map_bus_if.sv
verilog/bus_sync.sv
verilog/map_regs.sv
verilog/prg_chr_map.sv
verilog/irq_counter.sv
verilog/mul_acc.sv
verilog/map_090.sv
tests/map_090_chk.sv
tests/map_090_tb.sv

// ==== tests/map_090_chk.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module map_090_chk (
	input logic clk,
	input logic map_rst,
	input logic m2,
	input logic [15:0] cpu_addr,
	input logic cpu_rw,
	input logic ram_ce,
	input logic ram_we,
	input logic irq,
	input logic map_cpu_oe
);

	int err_cnt = 0; // failed assertions so far

	// prg ram sits at $6000-$7FFF
	a_ram_we_ce: assert property (@(posedge clk) disable iff (map_rst)
		ram_we |-> ram_ce && cpu_addr[15:13] == 3'b011)
	else
	begin
		err_cnt++;
		$error("ram write enable seen without ram chip enable or outside $6000-$7FFF");
	end

	// the mapper only drives the data bus during cpu reads of $5800-$5803
	a_oe_read: assert property (@(posedge clk) disable iff (map_rst)
		map_cpu_oe |-> cpu_rw && cpu_addr >= `MAP_MUL_BASE && cpu_addr <= `MAP_MUL_BASE + 16'd3)
	else
	begin
		err_cnt++;
		$error("mapper drives cpu data outside a read of $5800-$5803");
	end

	a_rst_irq: assert property (@(posedge clk) map_rst |=> !irq)
	else
	begin
		err_cnt++;
		$error("irq high after a reset cycle");
	end

	// write strobe cycle is seven high m2 samples after a low one
	a_irq_off: assert property (@(posedge clk) disable iff (map_rst)
		(!$past(m2, 8) && $past(m2, 7) && $past(m2, 1) && !cpu_rw
			&& cpu_addr == `MAP_IRQ_BASE + 16'd2) |=> !irq)
	else
	begin
		err_cnt++;
		$error("irq still high one cycle after the disable write");
	end

endmodule

// ==== tests/map_090_tb.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module map_090_tb;

	localparam int CPU_CYCLES = 69; // bus cycles over all tests
	localparam int PPU_STEPS = 40;
	localparam int WATCHDOG_NS = (4 + CPU_CYCLES * 24 + PPU_STEPS + 200) * 100;

	logic clk;
	logic map_rst;
	logic m2;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dat;
	logic cpu_rw;
	logic [13:0] ppu_addr;
	logic ppu_oe;
	logic [`MAP_PRG_AW-1:0] prg_addr;
	logic [`MAP_CHR_AW-1:0] chr_addr;
	logic ciram_a10;
	logic ciram_ce;
	logic rom_ce;
	logic ram_ce;
	logic ram_we;
	logic irq;
	logic [7:0] map_cpu_dout;
	logic map_cpu_oe;

	integer seed = 32'h991fa414;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;
	int mark = 0; // error count when the current test began
	logic [6:0] prg_val [4];
	logic [15:0] chr_val [8];
	logic [15:0] nt_val [4];
	logic [2:0] pmodes [3] = '{3'd6, 3'd4, 3'd7}; // 8K, 32K, reversed 8K
	logic [1:0] prg_outer;
	logic [1:0] chr_outer;
	logic [15:0] addr;
	logic [13:0] paddr;
	logic [7:0] opa;
	logic [7:0] opb;
	logic [7:0] sum;
	logic [7:0] val;
	logic [7:0] key;
	logic [15:0] prod;

	map_090 u_map_090 (.*);

	bind map_090 map_090_chk u_map_090_chk (
		.clk(clk),
		.map_rst(map_rst),
		.m2(m2),
		.cpu_addr(cpu_addr),
		.cpu_rw(cpu_rw),
		.ram_ce(ram_ce),
		.ram_we(ram_we),
		.irq(irq),
		.map_cpu_oe(map_cpu_oe)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// m2 low then high for 12 clocks each, returns mid-clock in the high phase
	task automatic cpu_cycle(input logic [15:0] a, input logic [7:0] d, input logic rw);
		@(posedge clk);
		#10;
		m2 = 1'b0;
		cpu_addr = a;
		cpu_dat = d;
		cpu_rw = rw;
		repeat (12) @(posedge clk);
		#10;
		m2 = 1'b1;
		repeat (11) @(posedge clk);
		#50;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu_cycle(a, d, 1'b0);
	endtask

	task automatic cpu_read(input logic [15:0] a);
		cpu_cycle(a, 8'h00, 1'b1);
	endtask

	task automatic ppu_drive(input logic [13:0] a);
		@(posedge clk);
		#10;
		ppu_addr = a;
		#40;
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == mark)
			$display("test %s: ok", name);
		else
		begin
			failed++;
			$display("test %s: %0d errors", name, errors - mark);
		end
		mark = errors;
	endtask

	// 8K bank number per prg mode, outer bits on top
	function automatic logic [20:0] prg_expect(input logic [2:0] pm, input logic [15:0] a);
		logic [6:0] b;
		logic [5:0] bank;
		b = prg_val[a[14:13]];
		case (pm)
			3'd4: bank = {prg_val[3][3:0], a[14:13]}; // 32K
			3'd7: bank = {b[1], b[2], b[3], b[4], b[5], b[6]};
			default: bank = b[5:0];
		endcase
		return {prg_outer, bank, a[12:0]};
	endfunction

	function automatic logic mirror_expect(input logic [1:0] mm, input logic ext,
		input logic [1:0] q);
		if (ext)
			return nt_val[q][0];
		case (mm)
			2'd0: return q[0]; // vertical
			2'd1: return q[1]; // horizontal
			default: return mm[0];
		endcase
	endfunction

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		map_rst = 1'b1;
		m2 = 1'b0;
		cpu_addr = 16'h0000;
		cpu_dat = 8'h00;
		cpu_rw = 1'b1;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		repeat (4) @(posedge clk);
		#10;
		map_rst = 1'b0;
		#40;
		compare("irq", 32'(irq), 32'd0);
		compare("map_cpu_oe", 32'(map_cpu_oe), 32'd0);
		end_test("reset");

		for (int i = 0; i < 4; i++)
		begin
			prg_val[i] = 7'($random(seed));
			cpu_write(16'h8000 + 16'(i), 8'(prg_val[i]));
		end
		prg_outer = 2'($random(seed));
		chr_outer = 2'($random(seed));
		cpu_write(`MAP_MODE_BASE + 16'd3, {2'b00, 1'b1, chr_outer, prg_outer, 1'b0}); // a18 from bank
		for (int m = 0; m < 3; m++)
		begin
			cpu_write(`MAP_MODE_BASE, {5'b00000, pmodes[m]});
			for (int w = 0; w < 4; w++)
			begin
				addr = {1'b1, 2'(w), 13'($random(seed))};
				cpu_read(addr);
				compare("prg_addr", 32'(prg_addr), 32'(prg_expect(pmodes[m], addr)));
				compare("prg_addr[12:0]", 32'(prg_addr[12:0]), 32'(addr[12:0]));
				compare("rom_ce", 32'(rom_ce), 32'd1);
				compare("ram_ce", 32'(ram_ce), 32'd0);
			end
		end
		end_test("prg_banking");

		for (int i = 0; i < 8; i++)
		begin
			chr_val[i] = 16'($random(seed));
			cpu_write(16'h9000 + 16'(i), chr_val[i][7:0]);
			cpu_write(16'hA000 + 16'(i), chr_val[i][15:8]);
		end
		for (int q = 0; q < 4; q++)
		begin
			nt_val[q] = 16'($random(seed));
			cpu_write(16'hB000 + 16'(q), nt_val[q][7:0]);
			cpu_write(16'hB004 + 16'(q), nt_val[q][15:8]);
		end
		cpu_write(`MAP_MODE_BASE, 8'h00); // chr 8K
		for (int i = 0; i < 8; i++)
		begin
			paddr = {1'b0, 3'(i), 10'($random(seed))};
			ppu_drive(paddr);
			compare("chr_addr", 32'(chr_addr), 32'({chr_outer, chr_val[0][5:0], paddr[12:0]}));
		end
		cpu_write(`MAP_MODE_BASE, 8'h18); // chr 1K
		for (int i = 0; i < 8; i++)
		begin
			paddr = {1'b0, 3'(i), 10'($random(seed))};
			ppu_drive(paddr);
			compare("chr_addr", 32'(chr_addr), 32'({chr_outer, chr_val[i][8:0], paddr[9:0]}));
			compare("ciram_ce", 32'(ciram_ce), 32'd1); // pattern fetch, ciram off
		end
		for (int q = 0; q < 4; q++)
		begin
			paddr = {2'b10, 2'(q), 10'($random(seed))};
			ppu_drive(paddr);
			compare("chr_addr", 32'(chr_addr), 32'({2'b00, nt_val[q][8:0], paddr[9:0]}));
			compare("ciram_ce", 32'(ciram_ce), 32'd0); // rom nametables off
		end
		end_test("chr_banking");

		for (int m = 0; m < 5; m++)
		begin
			cpu_write(`MAP_MODE_BASE + 16'd1, (m == 4) ? 8'h08 : 8'(m)); // last pass sets mir_ext
			for (int q = 0; q < 4; q++)
			begin
				ppu_drive({2'b10, 2'(q), 10'h155});
				compare("ciram_a10", 32'(ciram_a10), 32'(mirror_expect(2'(m), m == 4, 2'(q))));
			end
		end
		end_test("mirroring");

		opa = 8'($random(seed));
		opb = 8'($random(seed));
		prod = 16'(opa) * 16'(opb);
		cpu_write(`MAP_MUL_BASE, opa);
		cpu_write(`MAP_MUL_BASE + 16'd1, opb);
		cpu_read(`MAP_MUL_BASE);
		compare("map_cpu_oe", 32'(map_cpu_oe), 32'd1);
		compare("map_cpu_dout", 32'(map_cpu_dout), 32'(prod[7:0]));
		cpu_read(`MAP_MUL_BASE + 16'd1);
		compare("map_cpu_dout", 32'(map_cpu_dout), 32'(prod[15:8]));
		sum = 8'h00;
		for (int i = 0; i < 3; i++)
		begin
			val = 8'($random(seed));
			sum = sum + val; // wraps at 256
			cpu_write(`MAP_MUL_BASE + 16'd2, val);
		end
		cpu_read(`MAP_MUL_BASE + 16'd2);
		compare("map_cpu_dout", 32'(map_cpu_dout), 32'(sum));
		val = 8'($random(seed));
		cpu_write(`MAP_MUL_BASE + 16'd3, val);
		cpu_read(`MAP_MUL_BASE + 16'd2);
		compare("map_cpu_dout", 32'(map_cpu_dout), 32'd0);
		cpu_read(`MAP_MUL_BASE + 16'd3);
		compare("map_cpu_dout", 32'(map_cpu_dout), 32'(val));
		end_test("mul_acc");

		key = 8'($random(seed)) | 8'h01; // never zero
		cpu_write(`MAP_IRQ_BASE + 16'd6, key);
		cpu_write(`MAP_IRQ_BASE + 16'd1, 8'h43); // count up on cpu writes, 8-bit prescaler
		cpu_write(`MAP_IRQ_BASE + 16'd4, 8'hff ^ key);
		cpu_write(`MAP_IRQ_BASE + 16'd5, 8'hff ^ key);
		cpu_write(`MAP_IRQ_BASE + 16'd3, 8'h00);
		compare("irq", 32'(irq), 32'd0);
		cpu_write(16'h6000, 8'h5a); // one tick wraps both
		compare("irq", 32'(irq), 32'd1);
		compare("ram_ce", 32'(ram_ce), 32'd1); // prg ram at $6000
		compare("ram_we", 32'(ram_we), 32'd1);
		compare("rom_ce", 32'(rom_ce), 32'd0);
		cpu_write(`MAP_IRQ_BASE + 16'd2, 8'h00);
		compare("irq", 32'(irq), 32'd0);
		end_test("irq");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion errors",
			tests, failed, checks, errors, u_map_090.u_map_090_chk.err_cnt);
		if (errors == 0 && u_map_090.u_map_090_chk.err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog/bus_sync.sv ====
`timescale 1ns/100ps

module bus_sync (
	input logic clk,
	input logic map_rst,
	input logic m2,
	input logic ppu_a12,
	input logic ppu_oe,
	input logic cpu_rw,
	input logic [15:0] cpu_addr,
	input logic [7:0] cpu_dat,
	map_bus_if.src bus
);

	logic [7:0] m2_st;
	logic [7:0] a12_st;
	logic [7:0] oe_st;

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			m2_st <= '0;
			a12_st <= '0;
			oe_st <= '1; // oe idles high
		end
		else
		begin
			m2_st <= {m2_st[6:0], m2};
			a12_st <= {a12_st[6:0], ppu_a12};
			oe_st <= {oe_st[6:0], ppu_oe};
		end
	end

	// an edge counts only after seven stable samples, short glitches are ignored
	assign bus.m2_pe = m2_st == 8'b0111_1111;
	assign bus.a12_pe = a12_st == 8'b0111_1111;
	assign bus.oe_ne = oe_st == 8'b1000_0000;

	assign bus.cpu_addr = cpu_addr;
	assign bus.cpu_dat = cpu_dat;
	assign bus.cpu_rw = cpu_rw;

endmodule

// ==== verilog/irq_counter.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module irq_counter import map_pkg::*; (
	input logic clk,
	input logic map_rst,
	map_bus_if.snk bus,
	output logic irq
);

	logic irq_en;
	logic irq_pend;
	logic [7:0] irq_mod;
	logic [7:0] irq_pre;
	logic [7:0] irq_ctr;
	logic [7:0] irq_xor; // write key
	logic wr;
	logic en_nxt;
	logic tick;
	logic [7:0] pmask;
	logic [7:0] pre_nxt;
	irq_src_t src;
	irq_dir_t dir;

	assign wr = bus.m2_pe && !bus.cpu_rw && ({bus.cpu_addr[15:11], 11'd0} == `MAP_IRQ_BASE);
	assign src = irq_src_t'(irq_mod[1:0]);
	assign dir = irq_dir_t'(irq_mod[7:6]);
	assign pmask = irq_mod[2] ? 8'h07 : 8'hff; // 3-bit prescaler
	assign pre_nxt = (dir == IRQ_DOWN) ? irq_pre - 8'd1 : irq_pre + 8'd1;
	assign irq = irq_pend;

	always_comb
	begin
		case (src)
			IRQ_SRC_M2: tick = bus.m2_pe;
			IRQ_SRC_A12_RISE: tick = bus.a12_pe;
			IRQ_SRC_OE_FALL: tick = bus.oe_ne;
			default: tick = bus.m2_pe && !bus.cpu_rw;
		endcase
	end

	always_comb
	begin
		en_nxt = irq_en;
		if (wr && bus.cpu_addr[2:0] == 3'd0)
			en_nxt = bus.cpu_dat[0];
		else if (wr && bus.cpu_addr[2:0] == 3'd2)
			en_nxt = 1'b0;
		else if (wr && bus.cpu_addr[2:0] == 3'd3)
			en_nxt = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			irq_en <= 1'b0;
			irq_pend <= 1'b0;
			irq_mod <= '0;
		end
		else
		begin
			irq_en <= en_nxt;
			if (wr)
			begin
				case (bus.cpu_addr[2:0])
					3'd1: irq_mod <= bus.cpu_dat;
					3'd4: irq_pre <= bus.cpu_dat ^ irq_xor;
					3'd5: irq_ctr <= bus.cpu_dat ^ irq_xor;
					3'd6: irq_xor <= bus.cpu_dat;
					default:
					begin
					end
				endcase
			end
			if (irq_en && !en_nxt)
			begin
				irq_pre <= '0;
				irq_pend <= 1'b0;
			end
			else if (irq_en && tick && (dir == IRQ_UP || dir == IRQ_DOWN))
			begin
				irq_pre <= pre_nxt;
				if (dir == IRQ_UP && (pre_nxt & pmask) == 8'h00)
				begin
					irq_ctr <= irq_ctr + 8'd1;
					if (irq_ctr == 8'hff)
						irq_pend <= 1'b1;
				end
				if (dir == IRQ_DOWN && (pre_nxt & pmask) == pmask)
				begin
					irq_ctr <= irq_ctr - 8'd1;
					if (irq_ctr == 8'h00)
						irq_pend <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== verilog/map_090.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module map_090 import map_pkg::*; (
	input logic clk,
	input logic map_rst,
	input logic m2,
	input logic [15:0] cpu_addr,
	input logic [7:0] cpu_dat,
	input logic cpu_rw,
	input logic [13:0] ppu_addr,
	input logic ppu_oe,
	output logic [`MAP_PRG_AW-1:0] prg_addr,
	output logic [`MAP_CHR_AW-1:0] chr_addr,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic rom_ce,
	output logic ram_ce,
	output logic ram_we,
	output logic irq,
	output logic [7:0] map_cpu_dout,
	output logic map_cpu_oe
);

	map_bus_if bus ();

	prg_banks_t prg_banks;
	chr_banks_t chr_banks;
	nt_banks_t nt_banks;
	mode_regs_t mode;

	bus_sync u_bus_sync (
		.clk(clk),
		.map_rst(map_rst),
		.m2(m2),
		.ppu_a12(ppu_addr[12]),
		.ppu_oe(ppu_oe),
		.cpu_rw(cpu_rw),
		.cpu_addr(cpu_addr),
		.cpu_dat(cpu_dat),
		.bus(bus.src)
	);

	map_regs u_map_regs (
		.clk(clk),
		.map_rst(map_rst),
		.bus(bus.snk),
		.prg_banks(prg_banks),
		.chr_banks(chr_banks),
		.nt_banks(nt_banks),
		.mode(mode)
	);

	// address translation works on the live bus, no sampling delay
	prg_chr_map u_prg_chr_map (
		.cpu_addr(cpu_addr),
		.cpu_rw(cpu_rw),
		.ppu_addr(ppu_addr),
		.prg_banks(prg_banks),
		.chr_banks(chr_banks),
		.nt_banks(nt_banks),
		.mode(mode),
		.prg_addr(prg_addr),
		.chr_addr(chr_addr),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.rom_ce(rom_ce),
		.ram_ce(ram_ce),
		.ram_we(ram_we)
	);

	irq_counter u_irq_counter (
		.clk(clk),
		.map_rst(map_rst),
		.bus(bus.snk),
		.irq(irq)
	);

	mul_acc u_mul_acc (
		.clk(clk),
		.map_rst(map_rst),
		.bus(bus.snk),
		.map_cpu_dout(map_cpu_dout),
		.map_cpu_oe(map_cpu_oe)
	);

endmodule

// ==== verilog/map_bus_if.sv ====
`timescale 1ns/100ps

// sampled cpu bus plus the edge strobes derived from m2, a12 and ppu oe
interface map_bus_if;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dat;
	logic cpu_rw;
	logic m2_pe;  // one clk wide, cpu write commit point
	logic a12_pe; // ppu a12 rising
	logic oe_ne;  // ppu oe falling

	modport src (output cpu_addr, cpu_dat, cpu_rw, m2_pe, a12_pe, oe_ne);

	modport snk (input cpu_addr, cpu_dat, cpu_rw, m2_pe, a12_pe, oe_ne);

endinterface

// ==== verilog/map_pkg.sv ====
package map_pkg;

	// $8000-$8003, 8K PRG bank numbers
	typedef logic [3:0][6:0] prg_banks_t;

	// $9000-$9007 low byte, $A000-$A007 high byte
	typedef logic [7:0][15:0] chr_banks_t;

	// $B000-$B003 low byte, $B004-$B007 high byte
	typedef logic [3:0][15:0] nt_banks_t;

	typedef struct packed {
		logic [2:0] prg_mode;    // D000[2:0]
		logic [1:0] chr_mode;    // D000[4:3]
		logic       rom_ntb;     // D000[5]
		logic       rom_ntb_sel; // D000[6], rom for every nametable
		logic       rom_6000;    // D000[7], prg rom mapped at $6000
		logic [1:0] mir_mode;    // D001[1:0]
		logic       mir_ext;     // D001[3]
		logic [1:0] ntb_cmp;     // D002[7:6]
		logic [1:0] prg_outer;   // D003[2:1]
		logic [1:0] chr_outer;   // D003[4:3]
		logic       chr_a18_sel; // D003[5]
		logic       chr_a18;     // D003[0]
	} mode_regs_t;

	typedef enum logic [1:0] {
		IRQ_SRC_M2       = 2'd0,
		IRQ_SRC_A12_RISE = 2'd1,
		IRQ_SRC_OE_FALL  = 2'd2,
		IRQ_SRC_CPU_WR   = 2'd3
	} irq_src_t;

	typedef enum logic [1:0] {
		IRQ_HOLD = 2'd0,
		IRQ_UP   = 2'd1,
		IRQ_DOWN = 2'd2
	} irq_dir_t;

endpackage

// ==== verilog/map_regs.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module map_regs import map_pkg::*; (
	input logic clk,
	input logic map_rst,
	map_bus_if.snk bus,
	output prg_banks_t prg_banks,
	output chr_banks_t chr_banks,
	output nt_banks_t nt_banks,
	output mode_regs_t mode
);

	logic wr;
	logic mode_wr;

	assign wr = bus.m2_pe && !bus.cpu_rw;
	assign mode_wr = wr && ({bus.cpu_addr[15:11], 11'd0} == `MAP_MODE_BASE);

	// bank registers, each window is 2K wide and mirrored inside
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			case ({bus.cpu_addr[15:11], 11'd0})
				16'h8000:
				begin
					prg_banks[bus.cpu_addr[1:0]] <= bus.cpu_dat[6:0];
				end
				16'h9000:
				begin
					chr_banks[bus.cpu_addr[2:0]][7:0] <= bus.cpu_dat;
				end
				16'hA000:
				begin
					chr_banks[bus.cpu_addr[2:0]][15:8] <= bus.cpu_dat;
				end
				16'hB000:
				begin
					if (bus.cpu_addr[2])
						nt_banks[bus.cpu_addr[1:0]][15:8] <= bus.cpu_dat;
					else
						nt_banks[bus.cpu_addr[1:0]][7:0] <= bus.cpu_dat;
				end
				default:
				begin
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			mode <= '0;
		end
		else if (mode_wr)
		begin
			case (bus.cpu_addr[1:0])
				2'd0:
				begin
					mode.prg_mode <= bus.cpu_dat[2:0];
					mode.chr_mode <= bus.cpu_dat[4:3];
					mode.rom_ntb <= bus.cpu_dat[5];
					mode.rom_ntb_sel <= bus.cpu_dat[6];
					mode.rom_6000 <= bus.cpu_dat[7];
				end
				2'd1:
				begin
					mode.mir_mode <= bus.cpu_dat[1:0];
					mode.mir_ext <= bus.cpu_dat[3];
				end
				2'd2:
				begin
					mode.ntb_cmp <= bus.cpu_dat[7:6]; // rest of D002 not stored
				end
				default:
				begin
					mode.chr_a18 <= bus.cpu_dat[0];
					mode.prg_outer <= bus.cpu_dat[2:1];
					mode.chr_outer <= bus.cpu_dat[4:3];
					mode.chr_a18_sel <= bus.cpu_dat[5];
				end
			endcase
		end
	end

endmodule

// ==== verilog/mul_acc.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module mul_acc (
	input logic clk,
	input logic map_rst,
	map_bus_if.snk bus,
	output logic [7:0] map_cpu_dout,
	output logic map_cpu_oe
);

	logic [7:0] mul_arg0;
	logic [7:0] mul_arg1;
	logic mul_req; // product stale
	logic [15:0] mul_rez;
	logic [7:0] acc;
	logic [7:0] acc_test;
	logic wr;
	logic rd_win;

	assign wr = bus.m2_pe && !bus.cpu_rw && ({bus.cpu_addr[15:11], 11'd0} == `MAP_MUL_BASE);
	assign rd_win = {bus.cpu_addr[15:2], 2'b00} == `MAP_MUL_BASE; // reads not mirrored

	always_ff @(posedge clk)
	begin
		if (map_rst)
		begin
			mul_req <= 1'b0;
			acc <= '0;
		end
		else if (bus.m2_pe)
		begin
			if (mul_req)
			begin
				mul_rez <= mul_arg0 * mul_arg1;
				mul_req <= 1'b0;
			end
			// a new operand write wins over the clear above
			if (wr)
			begin
				case (bus.cpu_addr[1:0])
					2'd0:
					begin
						mul_arg0 <= bus.cpu_dat;
						mul_req <= 1'b1;
					end
					2'd1:
					begin
						mul_arg1 <= bus.cpu_dat;
						mul_req <= 1'b1;
					end
					2'd2: acc <= acc + bus.cpu_dat;
					default:
					begin
						acc <= '0;
						acc_test <= bus.cpu_dat;
					end
				endcase
			end
		end
	end

	assign map_cpu_oe = bus.cpu_rw && rd_win;

	always_comb
	begin
		case (bus.cpu_addr[1:0])
			2'd0: map_cpu_dout = mul_rez[7:0];
			2'd1: map_cpu_dout = mul_rez[15:8];
			2'd2: map_cpu_dout = acc;
			default: map_cpu_dout = acc_test;
		endcase
	end

endmodule

// ==== verilog/prg_chr_map.sv ====
`timescale 1ns/100ps
`include "map_defs.svh"

module prg_chr_map import map_pkg::*; (
	input logic [15:0] cpu_addr,
	input logic cpu_rw,
	input logic [13:0] ppu_addr,
	input prg_banks_t prg_banks,
	input chr_banks_t chr_banks,
	input nt_banks_t nt_banks,
	input mode_regs_t mode,
	output logic [`MAP_PRG_AW-1:0] prg_addr,
	output logic [`MAP_CHR_AW-1:0] chr_addr,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic rom_ce,
	output logic ram_ce,
	output logic ram_we
);

	logic [6:0] prg_8k;
	logic [6:0] prg_rev;
	logic [6:0] prg_sw;
	logic [6:0] prg_bank;
	logic [8:0] chr_map;
	logic chr_hi;
	logic [1:0] nt_q;
	logic ce_6000;

	assign nt_q = ppu_addr[11:10];
	assign ce_6000 = cpu_addr[15:13] == 3'b011;
	assign prg_8k = prg_banks[cpu_addr[14:13]];

	always_comb
	begin
		for (int i = 0; i < 7; i++)
			prg_rev[i] = prg_8k[6 - i];
	end

	// modes 4-7 fully switchable, modes 0-3 pin the last window to the top bank
	always_comb
	begin
		case (mode.prg_mode[1:0])
			2'd0: prg_sw = {prg_banks[3][4:0], cpu_addr[14:13]}; // 32K
			2'd1: prg_sw = cpu_addr[14] ? {prg_banks[3][5:0], cpu_addr[13]}
				: {prg_banks[1][5:0], cpu_addr[13]}; // 16K
			2'd2: prg_sw = prg_8k;
			default: prg_sw = prg_rev;
		endcase
		prg_bank = prg_sw;
		if (!mode.prg_mode[2])
		begin
			case (mode.prg_mode[1:0])
				2'd0:
				begin
					if (cpu_addr[15])
						prg_bank = {5'h1f, cpu_addr[14:13]};
				end
				2'd1:
				begin
					if (cpu_addr[15:14] == 2'b11)
						prg_bank = {6'h3f, cpu_addr[13]};
				end
				default:
				begin
					if (cpu_addr[15:13] == 3'b111)
						prg_bank = 7'h7f;
				end
			endcase
		end
	end

	assign prg_addr = {mode.prg_outer, prg_bank[5:0], cpu_addr[12:0]};

	always_comb
	begin
		case (mode.chr_mode)
			2'd0: chr_map = {chr_banks[0][5:0], ppu_addr[12:10]}; // 8K
			2'd1: chr_map = {chr_banks[{ppu_addr[12], 2'b00}][6:0], ppu_addr[11:10]}; // 4K
			2'd2: chr_map = {chr_banks[{ppu_addr[12:11], 1'b0}][7:0], ppu_addr[10]}; // 2K
			default: chr_map = chr_banks[ppu_addr[12:10]][8:0]; // 1K
		endcase
	end

	assign chr_hi = mode.chr_a18_sel ? chr_map[8] : mode.chr_a18;

	// nametable fetches take the $B00X bank instead of a chr bank
	assign chr_addr = ppu_addr[13] ? {2'b00, nt_banks[nt_q][8:0], ppu_addr[9:0]}
		: {mode.chr_outer, chr_hi, chr_map[7:0], ppu_addr[9:0]};

	always_comb
	begin
		if (mode.mir_ext)
			ciram_a10 = nt_banks[nt_q][0]; // per-quarter select
		else if (mode.mir_mode == 2'd0)
			ciram_a10 = ppu_addr[10]; // vertical
		else if (mode.mir_mode == 2'd1)
			ciram_a10 = ppu_addr[11]; // horizontal
		else
			ciram_a10 = mode.mir_mode[0]; // single screen
	end

	// ciram_ce is active low like the cartridge pin
	always_comb
	begin
		if (!ppu_addr[13])
			ciram_ce = 1'b1;
		else if (!mode.rom_ntb)
			ciram_ce = 1'b0;
		else if (mode.rom_ntb_sel)
			ciram_ce = 1'b1;
		else
			ciram_ce = mode.ntb_cmp[1] != nt_banks[nt_q][7]; // rom when bit 7 differs
	end

	assign rom_ce = cpu_addr[15] | (ce_6000 & mode.rom_6000);
	assign ram_ce = ce_6000 & !mode.rom_6000;
	assign ram_we = ram_ce & !cpu_rw;

endmodule
